// ==== async_asym_fifo.f ====
design/fifo_cfg_pkg.sv
design/fifo_types_pkg.sv
design/gray_ptr_sync.sv
design/fifo_wr_ctrl.sv
design/fifo_rd_ctrl.sv
design/asym_dp_ram.sv
design/async_asym_fifo.sv
test/tb_clk_gen.sv
test/async_asym_fifo_assert.sv
test/async_asym_fifo_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and scan the log for the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f async_asym_fifo.f --top-module async_asym_fifo_tb \
   -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q "sim failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "sim passed" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

// ==== test/async_asym_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module async_asym_fifo_tb;

   import fifo_cfg_pkg::*;
   import fifo_types_pkg::*;

   localparam int W_PERIOD = 14;
   localparam int R_PERIOD = 20;
   localparam int RATIO    = DEF_R_DATA_W / DEF_W_DATA_W;
   localparam int N_RANDOM = 500;
   // directed writes plus the random run
   localparam int N_XFERS  = N_RANDOM + 84;
   localparam int MARGIN   = 10;

   logic                    w_clk;
   logic                    r_clk;
   logic                    rst_n;
   logic                    w_en;
   logic [DEF_W_DATA_W-1:0] w_data;
   logic                    r_en;
   logic [DEF_R_DATA_W-1:0] r_data;
   wr_status_t              w_stat;
   rd_status_t              r_stat;

   integer                  seed = 32'h89f3_a47b;
   logic [DEF_W_DATA_W-1:0] ref_q[$];
   logic [DEF_R_DATA_W-1:0] hold_exp = '0;
   int                      val_errs = 0;
   int                      other_errs = 0;
   int                      wr_count = 0;
   int                      rd_count = 0;
   int                      wr_target;

   tb_clk_gen #(.PERIOD_NS(W_PERIOD)) u_w_clk_gen (.clk(w_clk));
   tb_clk_gen #(.PERIOD_NS(R_PERIOD)) u_r_clk_gen (.clk(r_clk));

   async_asym_fifo #(
      .W_DATA_W (DEF_W_DATA_W),
      .R_DATA_W (DEF_R_DATA_W),
      .ADDR_W   (DEF_ADDR_W)
   ) i_async_asym_fifo (.*);

   // oldest byte goes to the low byte of the read word
   function automatic logic [DEF_R_DATA_W-1:0] pack_oldest(input logic [DEF_W_DATA_W-1:0] q[$]);
      logic [DEF_R_DATA_W-1:0] word;
      word = '0;
      for (int i = 0; i < RATIO; i++) begin
         word[i*DEF_W_DATA_W +: DEF_W_DATA_W] = q[i];
      end
      return word;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      val_errs++;
   endtask

   task automatic report_failure(input string what);
      $display("Failure at %0d ns: %s", $time, what);
      other_errs++;
   endtask

   // poll on falling r_clk edges, give up after 200 cycles
   task automatic wait_empty(input logic val);
      int n;
      n = 0;
      while (r_stat.empty !== val && n < 200) begin
         @(negedge r_clk);
         n++;
      end
      if (r_stat.empty !== val) begin
         report_failure("empty flag did not reach the awaited value");
      end
   endtask

   // every accepted write goes into the reference queue
   always @(posedge w_clk) begin
      if (rst_n && w_en && !w_stat.full) begin
         ref_q.push_back(w_data);
         wr_count++;
      end
   end

   // r_data holds the last popped word until the next accepted read
   always @(posedge r_clk) begin
      if (rst_n && r_data !== hold_exp) begin
         report_mismatch("r_data", hold_exp, r_data);
      end
      if (rst_n && r_en && !r_stat.empty) begin
         if (ref_q.size() < RATIO) begin
            report_failure("read accepted before a whole word was written");
         end else begin
            hold_exp = pack_oldest(ref_q);
            for (int i = 0; i < RATIO; i++) begin
               void'(ref_q.pop_front());
            end
            rd_count++;
         end
      end
   end

   initial begin
      #(N_XFERS * R_PERIOD * MARGIN);
      $display("Failure: run did not finish in %0d ns", N_XFERS * R_PERIOD * MARGIN);
      $display("sim failed");
      $finish;
   end

   initial begin
      rst_n  = 1'b0;
      w_en   = 1'b0;
      w_data = '0;
      r_en   = 1'b0;
      repeat (8) @(posedge r_clk);
      @(negedge r_clk);
      rst_n = 1'b1;

      // idle state after reset
      @(negedge r_clk);
      if (r_stat.empty !== 1'b1) begin
         report_mismatch("r_stat.empty", 1, r_stat.empty);
      end
      if (w_stat.full !== 1'b0) begin
         report_mismatch("w_stat.full", 0, w_stat.full);
      end
      if (r_stat.level !== '0) begin
         report_mismatch("r_stat.level", 0, r_stat.level);
      end
      if (w_stat.level !== '0) begin
         report_mismatch("w_stat.level", 0, w_stat.level);
      end

      // four bytes, then one read word
      for (int i = 0; i < RATIO; i++) begin
         @(negedge w_clk);
         w_en   = 1'b1;
         w_data = 8'(8'h11 * (i + 1));
      end
      @(negedge w_clk);
      w_en = 1'b0;
      wait_empty(1'b0);
      r_en = 1'b1;
      @(negedge r_clk);
      r_en = 1'b0;

      // fill, the surplus writes carry fresh data and must be dropped
      for (int n = 0; n < 80; n++) begin
         @(negedge w_clk);
         w_en   = 1'b1;
         w_data = 8'(8'h40 + n);
      end
      w_en = 1'b0;
      if (w_stat.full !== 1'b1) begin
         report_mismatch("w_stat.full", 1, w_stat.full);
      end
      if (w_stat.level !== 11'((1 << DEF_ADDR_W) - 1)) begin
         report_mismatch("w_stat.level", (1 << DEF_ADDR_W) - 1, w_stat.level);
      end
      // read side counts only whole words
      if (r_stat.level !== 11'(((1 << DEF_ADDR_W) - 1) / RATIO)) begin
         report_mismatch("r_stat.level", ((1 << DEF_ADDR_W) - 1) / RATIO, r_stat.level);
      end

      // drain, then keep r_en high on an empty FIFO
      @(negedge r_clk);
      r_en = 1'b1;
      wait_empty(1'b1);
      repeat (4) @(negedge r_clk);
      r_en = 1'b0;
      if (ref_q.size() != (RATIO + (1 << DEF_ADDR_W) - 1) % RATIO) begin
         report_failure("bytes left after the drain do not match the fill count");
      end

      // random traffic on both sides
      wr_target = wr_count + N_RANDOM;
      fork
         begin
            @(negedge w_clk);
            while (wr_count < wr_target) begin
               w_en   = 1'($random(seed));
               w_data = 8'($random(seed));
               @(negedge w_clk);
            end
            w_en = 1'b0;
         end
         begin
            while (wr_count < wr_target) begin
               @(negedge r_clk);
               r_en = 1'($random(seed));
            end
         end
      join

      // pull out every whole word that is left
      @(negedge r_clk);
      r_en = 1'b1;
      for (int n = 0; n < 400 && ref_q.size() >= RATIO; n++) begin
         @(negedge r_clk);
      end
      r_en = 1'b0;
      repeat (4) @(negedge r_clk);
      if (rd_count != wr_count / RATIO) begin
         report_failure("number of words read does not match the bytes written");
      end

      $display("checks done: %0d value errors, %0d other errors", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/async_asym_fifo_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module async_asym_fifo_assert #(
   parameter int W_DATA_W = fifo_cfg_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_cfg_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_cfg_pkg::DEF_ADDR_W
) (
   input logic                                                     w_clk,
   input logic                                                     r_clk,
   input logic                                                     rst_n,
   input logic [fifo_cfg_pkg::ptr_w(W_DATA_W, R_DATA_W, ADDR_W)-1:0] wr_addr,
   input fifo_types_pkg::wr_status_t                               w_stat,
   input fifo_types_pkg::rd_status_t                               r_stat
);

   // sizes in units of the narrower port
   localparam int MIN_W   = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int W_RATIO = W_DATA_W / MIN_W;
   localparam int R_RATIO = R_DATA_W / MIN_W;

   a_full_known: assert property (@(posedge w_clk) disable iff (!rst_n)
      !$isunknown(w_stat.full)) else $error("full flag is unknown");

   a_empty_known: assert property (@(posedge r_clk) disable iff (!rst_n)
      !$isunknown(r_stat.empty)) else $error("empty flag is unknown");

   // write pointer holds over every edge that sees full
   a_no_write_when_full: assert property (@(posedge w_clk) disable iff (!rst_n)
      w_stat.full |=> $stable(wr_addr)) else $error("write accepted while full");

   // both sides see a stale foreign pointer, so the read side
   // never counts more data than the write side still holds
   a_rd_level_bound: assert property (@(posedge r_clk) disable iff (!rst_n)
      int'(r_stat.level) * R_RATIO <= int'(w_stat.level) * W_RATIO)
      else $error("read level above the data the write side holds");

endmodule

bind async_asym_fifo async_asym_fifo_assert #(
   .W_DATA_W (W_DATA_W),
   .R_DATA_W (R_DATA_W),
   .ADDR_W   (ADDR_W)
) u_assert (
   .w_clk   (w_clk),
   .r_clk   (r_clk),
   .rst_n   (rst_n),
   .wr_addr (wr_addr),
   .w_stat  (w_stat),
   .r_stat  (r_stat)
);

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS = 20
) (
   output logic clk
);

   // free running, low for the first half period
   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0);
         clk = ~clk;
      end
   end

endmodule

`default_nettype wire

// ==== design/async_asym_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module async_asym_fifo #(
   parameter int W_DATA_W = fifo_cfg_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_cfg_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_cfg_pkg::DEF_ADDR_W
) (
   input  logic                       w_clk,
   input  logic                       r_clk,
   input  logic                       rst_n,
   input  logic                       w_en,
   input  logic [W_DATA_W-1:0]        w_data,
   input  logic                       r_en,
   output logic [R_DATA_W-1:0]        r_data,
   output fifo_types_pkg::wr_status_t w_stat,
   output fifo_types_pkg::rd_status_t r_stat
);

   import fifo_cfg_pkg::*;

   localparam int WP_W  = ptr_w(W_DATA_W, R_DATA_W, ADDR_W);
   localparam int RP_W  = ptr_w(R_DATA_W, W_DATA_W, ADDR_W);
   localparam int MAX_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MIN_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;

   typedef logic [WP_W-1:0] wr_ptr_t;
   typedef logic [RP_W-1:0] rd_ptr_t;

   // configuration checks
   if (ADDR_W > FIFO_MAX_ADDR_W) begin : g_bad_addr_w
      $error("ADDR_W above FIFO_MAX_ADDR_W");
   end
   if ((MAX_W % MIN_W != 0) || (((MAX_W / MIN_W) & (MAX_W / MIN_W - 1)) != 0)) begin : g_bad_ratio
      $error("width ratio is not a power of two");
   end

   wr_ptr_t wr_addr;
   wr_ptr_t wr_gray;
   wr_ptr_t wr_gray_sync;
   rd_ptr_t rd_addr;
   rd_ptr_t rd_gray;
   rd_ptr_t rd_gray_sync;
   logic    wr_strobe;
   logic    rd_strobe;

   fifo_wr_ctrl #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_wr_ctrl (
      .w_clk        (w_clk),
      .rst_n        (rst_n),
      .w_en         (w_en),
      .rd_gray_sync (rd_gray_sync),
      .wr_addr      (wr_addr),
      .wr_strobe    (wr_strobe),
      .wr_gray      (wr_gray),
      .stat         (w_stat)
   );

   fifo_rd_ctrl #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_rd_ctrl (
      .r_clk        (r_clk),
      .rst_n        (rst_n),
      .r_en         (r_en),
      .wr_gray_sync (wr_gray_sync),
      .rd_addr      (rd_addr),
      .rd_strobe    (rd_strobe),
      .rd_gray      (rd_gray),
      .stat         (r_stat)
   );

   // write pointer into the read domain
   gray_ptr_sync #(
      .ptr_t (wr_ptr_t)
   ) u_wr_ptr_sync (
      .clk      (r_clk),
      .rst_n    (rst_n),
      .gray_in  (wr_gray),
      .gray_out (wr_gray_sync)
   );

   // read pointer into the write domain
   gray_ptr_sync #(
      .ptr_t (rd_ptr_t)
   ) u_rd_ptr_sync (
      .clk      (w_clk),
      .rst_n    (rst_n),
      .gray_in  (rd_gray),
      .gray_out (rd_gray_sync)
   );

   asym_dp_ram #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_ram (
      .w_clk     (w_clk),
      .wr_strobe (wr_strobe),
      .wr_addr   (wr_addr),
      .w_data    (w_data),
      .r_clk     (r_clk),
      .rst_n     (rst_n),
      .rd_strobe (rd_strobe),
      .rd_addr   (rd_addr),
      .r_data    (r_data)
   );

endmodule

`default_nettype wire

// ==== design/asym_dp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module asym_dp_ram #(
   parameter int W_DATA_W = fifo_cfg_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_cfg_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_cfg_pkg::DEF_ADDR_W
) (
   // write port
   input  logic                                                     w_clk,
   input  logic                                                     wr_strobe,
   input  logic [fifo_cfg_pkg::ptr_w(W_DATA_W, R_DATA_W, ADDR_W)-1:0] wr_addr,
   input  logic [W_DATA_W-1:0]                                      w_data,
   // read port
   input  logic                                                     r_clk,
   input  logic                                                     rst_n,
   input  logic                                                     rd_strobe,
   input  logic [fifo_cfg_pkg::ptr_w(R_DATA_W, W_DATA_W, ADDR_W)-1:0] rd_addr,
   output logic [R_DATA_W-1:0]                                      r_data
);

   localparam int MIN_W   = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int W_RATIO = W_DATA_W / MIN_W;
   localparam int R_RATIO = R_DATA_W / MIN_W;
   localparam int DEPTH   = 1 << ADDR_W;

   // narrow entries, a wide word spans adjacent ones
   logic [MIN_W-1:0] mem [0:DEPTH-1];

   // lowest part of a wide write goes to the lowest address
   always_ff @(posedge w_clk) begin
      if (wr_strobe) begin
         for (int i = 0; i < W_RATIO; i++) begin
            mem[ADDR_W'(wr_addr * W_RATIO + i)] <= w_data[i*MIN_W +: MIN_W];
         end
      end
   end

   // registered read, held until the next pop
   always_ff @(posedge r_clk or negedge rst_n) begin
      if (!rst_n) begin
         r_data <= '0;
      end else if (rd_strobe) begin
         for (int i = 0; i < R_RATIO; i++) begin
            r_data[i*MIN_W +: MIN_W] <= mem[ADDR_W'(rd_addr * R_RATIO + i)];
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/fifo_rd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_rd_ctrl #(
   parameter int W_DATA_W = fifo_cfg_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_cfg_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_cfg_pkg::DEF_ADDR_W
) (
   input  logic                                                     r_clk,
   input  logic                                                     rst_n,
   input  logic                                                     r_en,
   input  logic [fifo_cfg_pkg::ptr_w(W_DATA_W, R_DATA_W, ADDR_W)-1:0] wr_gray_sync,
   output logic [fifo_cfg_pkg::ptr_w(R_DATA_W, W_DATA_W, ADDR_W)-1:0] rd_addr,
   output logic                                                     rd_strobe,
   output logic [fifo_cfg_pkg::ptr_w(R_DATA_W, W_DATA_W, ADDR_W)-1:0] rd_gray,
   output fifo_types_pkg::rd_status_t                               stat
);

   import fifo_cfg_pkg::*;
   import fifo_types_pkg::*;

   localparam int WP_W = ptr_w(W_DATA_W, R_DATA_W, ADDR_W);
   localparam int RP_W = ptr_w(R_DATA_W, W_DATA_W, ADDR_W);

   logic [RP_W-1:0] rd_bin;
   logic [RP_W-1:0] rd_bin_next;
   logic [WP_W-1:0] wr_bin;
   logic [RP_W-1:0] wr_norm;
   logic [RP_W-1:0] level;
   logic            empty;

   assign rd_bin_next = rd_bin + 1'b1;

   // binary counter and its registered gray copy
   always_ff @(posedge r_clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else if (rd_strobe) begin
         rd_bin  <= rd_bin_next;
         rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
      end
   end

   // gray to binary on the synchronized write pointer
   always_comb begin
      for (int i = 0; i < WP_W; i++) begin
         wr_bin[i] = ^(wr_gray_sync >> i);
      end
   end

   // scale write pointer to read words, partial words stay hidden
   if (RP_W >= WP_W) begin : g_wr_up
      assign wr_norm = RP_W'(wr_bin) << (RP_W - WP_W);
   end else begin : g_wr_down
      assign wr_norm = RP_W'(wr_bin >> (WP_W - RP_W));
   end

   assign level     = wr_norm - rd_bin;
   assign empty     = (level == '0);
   assign rd_strobe = r_en & ~empty;
   assign rd_addr   = rd_bin;

   assign stat.empty = empty;
   assign stat.level = level_t'(level);

endmodule

`default_nettype wire

// ==== design/fifo_wr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_wr_ctrl #(
   parameter int W_DATA_W = fifo_cfg_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_cfg_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_cfg_pkg::DEF_ADDR_W
) (
   input  logic                                                     w_clk,
   input  logic                                                     rst_n,
   input  logic                                                     w_en,
   input  logic [fifo_cfg_pkg::ptr_w(R_DATA_W, W_DATA_W, ADDR_W)-1:0] rd_gray_sync,
   output logic [fifo_cfg_pkg::ptr_w(W_DATA_W, R_DATA_W, ADDR_W)-1:0] wr_addr,
   output logic                                                     wr_strobe,
   output logic [fifo_cfg_pkg::ptr_w(W_DATA_W, R_DATA_W, ADDR_W)-1:0] wr_gray,
   output fifo_types_pkg::wr_status_t                               stat
);

   import fifo_cfg_pkg::*;
   import fifo_types_pkg::*;

   localparam int WP_W = ptr_w(W_DATA_W, R_DATA_W, ADDR_W);
   localparam int RP_W = ptr_w(R_DATA_W, W_DATA_W, ADDR_W);

   // depth minus one, the last slot is never filled
   localparam logic [WP_W-1:0] FULL_LEVEL = '1;

   logic [WP_W-1:0] wr_bin;
   logic [WP_W-1:0] wr_bin_next;
   logic [RP_W-1:0] rd_bin;
   logic [WP_W-1:0] rd_norm;
   logic [WP_W-1:0] level;
   logic            full;

   assign wr_bin_next = wr_bin + 1'b1;

   // binary counter and its registered gray copy
   always_ff @(posedge w_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else if (wr_strobe) begin
         wr_bin  <= wr_bin_next;
         wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
      end
   end

   // gray to binary on the synchronized read pointer
   always_comb begin
      for (int i = 0; i < RP_W; i++) begin
         rd_bin[i] = ^(rd_gray_sync >> i);
      end
   end

   // scale read pointer to write words
   if (WP_W >= RP_W) begin : g_rd_up
      assign rd_norm = WP_W'(rd_bin) << (WP_W - RP_W);
   end else begin : g_rd_down
      assign rd_norm = WP_W'(rd_bin >> (RP_W - WP_W));
   end

   assign level     = wr_bin - rd_norm;
   assign full      = (level == FULL_LEVEL);
   assign wr_strobe = w_en & ~full;
   assign wr_addr   = wr_bin;

   assign stat.full  = full;
   assign stat.level = level_t'(level);

endmodule

`default_nettype wire

// ==== design/gray_ptr_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync #(
   parameter type ptr_t = logic [5:0]
) (
   input  logic clk,
   input  logic rst_n,
   input  ptr_t gray_in,
   output ptr_t gray_out
);

   // first stage may go metastable
   ptr_t meta;

   // only one bit moves per pointer step, so the second stage
   // always holds either the old or the new pointer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         meta     <= '0;
         gray_out <= '0;
      end else begin
         meta     <= gray_in;
         gray_out <= meta;
      end
   end

endmodule

`default_nettype wire

// ==== design/fifo_types_pkg.sv ====
`default_nettype none

package fifo_types_pkg;

   // level in words of the owning side, zero-extended
   typedef logic [fifo_cfg_pkg::FIFO_MAX_ADDR_W:0] level_t;

   // write side status
   typedef struct packed {
      logic   full;
      level_t level;
   } wr_status_t;

   // read side status
   typedef struct packed {
      logic   empty;
      level_t level;
   } rd_status_t;

endpackage

`default_nettype wire

// ==== design/fifo_cfg_pkg.sv ====
`default_nettype none

package fifo_cfg_pkg;

   // largest supported ADDR_W, sizes the level fields in the status structs
   localparam int FIFO_MAX_ADDR_W = 10;

   // default configuration
   localparam int DEF_W_DATA_W = 8;
   localparam int DEF_R_DATA_W = 32;
   localparam int DEF_ADDR_W   = 6;

   // pointer width of one side
   // the wider side addresses fewer, larger words
   function automatic int ptr_w(input int own_w, input int other_w, input int addr_w);
      if (own_w > other_w) begin
         return addr_w - $clog2(own_w / other_w);
      end
      return addr_w;
   endfunction

endpackage

`default_nettype wire
